// ==== perip_pkg.sv ====
//--------------------
// perip package
// bus widths, burst and response codes, register map,
// write request struct and controller states
//--------------------
package perip_pkg;

    // widths that carry a meaning on the bus
    typedef logic [15:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0]  strb_t;
    typedef logic [7:0]  axi_len_t;   // beats minus one
    typedef logic [1:0]  burst_t;
    typedef logic [1:0]  resp_t;

    localparam burst_t BURST_FIXED = 2'd0;
    localparam burst_t BURST_INCR  = 2'd1;
    localparam burst_t BURST_WRAP  = 2'd2;   // 3 is reserved, treated as incr

    localparam resp_t RESP_OKAY = 2'd0;

    localparam int BEAT_BYTES = 4;

    // register map, byte offsets
    localparam addr_t REG_LED    = 16'h0000;
    localparam addr_t REG_SEG_LO = 16'h0004;
    localparam addr_t REG_SEG_HI = 16'h0008;  // only bits 7:0 live
    localparam addr_t REG_SW_LO  = 16'h0010;
    localparam addr_t REG_SW_HI  = 16'h0014;
    localparam addr_t REG_KEY    = 16'h0018;

    // one register write from the write controller
    typedef struct packed {
        addr_t addr;
        data_t data;
        strb_t strb;
    } perip_wr_req_t;

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_DATA,
        WR_RESP
    } wr_state_t;

    typedef enum logic {
        RD_IDLE,
        RD_DATA
    } rd_state_t;

endpackage

// ==== axi_burst_addr.sv ====
//--------------------
// axi burst address step
// next beat address for fixed, incr and wrap bursts,
// 4 bytes per beat
//--------------------
`timescale 1ns/10ps

module axi_burst_addr (
    input  perip_pkg::addr_t    cur_addr,
    input  perip_pkg::burst_t   burst,
    input  perip_pkg::axi_len_t len,
    output perip_pkg::addr_t    next_addr
);

    perip_pkg::addr_t aligned;
    perip_pkg::addr_t incr_addr;
    perip_pkg::addr_t wrap_size;
    perip_pkg::addr_t wrap_mask;
    perip_pkg::addr_t wrap_addr;

    assign aligned   = {cur_addr[15:2], 2'b00};
    assign incr_addr = aligned + perip_pkg::addr_t'(perip_pkg::BEAT_BYTES);

    // block of (len+1) beats, power of two for legal wrap lengths
    assign wrap_size = (perip_pkg::addr_t'(len) + 16'd1)
                       * perip_pkg::addr_t'(perip_pkg::BEAT_BYTES);
    assign wrap_mask = wrap_size - 16'd1;

    // upper bits stay in the block, low bits roll over
    assign wrap_addr = (aligned & ~wrap_mask) | (incr_addr & wrap_mask);

    always_comb begin
        case (burst)
            perip_pkg::BURST_FIXED: begin
                next_addr = cur_addr;   // same address every beat
            end
            perip_pkg::BURST_WRAP: begin
                next_addr = wrap_addr;
            end
            default: begin
                // incr, and the reserved code
                next_addr = incr_addr;
            end
        endcase
    end

endmodule

// ==== axi_write_ctrl.sv ====
//--------------------
// axi write controller
// one burst at a time over aw, w and b;
// each accepted w beat becomes a strobed register write
//--------------------
`timescale 1ns/10ps

module axi_write_ctrl #(
    parameter int ID_WIDTH = 4
) (
    input  logic                     S_AXI_ACLK,
    input  logic                     S_AXI_ARESETN,
    input  logic [ID_WIDTH-1:0]      S_AXI_AWID,
    input  perip_pkg::addr_t         S_AXI_AWADDR,
    input  perip_pkg::axi_len_t      S_AXI_AWLEN,
    input  perip_pkg::burst_t        S_AXI_AWBURST,
    input  logic                     S_AXI_AWVALID,
    output logic                     S_AXI_AWREADY,
    input  perip_pkg::data_t         S_AXI_WDATA,
    input  perip_pkg::strb_t         S_AXI_WSTRB,
    input  logic                     S_AXI_WLAST,
    input  logic                     S_AXI_WVALID,
    output logic                     S_AXI_WREADY,
    output logic [ID_WIDTH-1:0]      S_AXI_BID,
    output perip_pkg::resp_t         S_AXI_BRESP,
    output logic                     S_AXI_BVALID,
    input  logic                     S_AXI_BREADY,
    output perip_pkg::perip_wr_req_t wr_req,
    output logic                     wr_en
);

    perip_pkg::wr_state_t state;
    logic [ID_WIDTH-1:0]  aw_id;
    perip_pkg::burst_t    aw_burst;
    perip_pkg::axi_len_t  aw_len;
    perip_pkg::addr_t     beat_addr;
    perip_pkg::addr_t     next_addr;
    perip_pkg::axi_len_t  beat_cnt;
    logic                 aw_hs;
    logic                 w_hs;

    assign S_AXI_AWREADY = (state == perip_pkg::WR_IDLE);
    assign S_AXI_WREADY  = (state == perip_pkg::WR_DATA);
    assign S_AXI_BVALID  = (state == perip_pkg::WR_RESP);
    assign S_AXI_BID     = aw_id;
    assign S_AXI_BRESP   = perip_pkg::RESP_OKAY;

    assign aw_hs = S_AXI_AWVALID && S_AXI_AWREADY;
    assign w_hs  = S_AXI_WVALID && S_AXI_WREADY;

    // write lands on the same edge as the w handshake
    assign wr_en       = w_hs;
    assign wr_req.addr = beat_addr;
    assign wr_req.data = S_AXI_WDATA;
    assign wr_req.strb = S_AXI_WSTRB;

    axi_burst_addr i_axi_burst_addr (
        .cur_addr  (beat_addr),
        .burst     (aw_burst),
        .len       (aw_len),
        .next_addr (next_addr)
    );

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            state <= perip_pkg::WR_IDLE;
        end else begin
            case (state)
                perip_pkg::WR_IDLE: if (aw_hs) state <= perip_pkg::WR_DATA;
                perip_pkg::WR_DATA: if (w_hs && S_AXI_WLAST) state <= perip_pkg::WR_RESP;
                perip_pkg::WR_RESP: if (S_AXI_BREADY) state <= perip_pkg::WR_IDLE;
                default:            state <= perip_pkg::WR_IDLE;
            endcase
        end
    end

    // burst context, loaded on aw
    always_ff @(posedge S_AXI_ACLK) begin
        if (aw_hs) begin
            aw_id     <= S_AXI_AWID;
            aw_burst  <= S_AXI_AWBURST;
            aw_len    <= S_AXI_AWLEN;
            beat_addr <= S_AXI_AWADDR;
            beat_cnt  <= '0;
        end else if (w_hs && beat_cnt != aw_len) begin
            // beats past awlen keep hitting the last address
            beat_addr <= next_addr;
            beat_cnt  <= beat_cnt + 8'd1;
        end
    end

endmodule

// ==== axi_read_ctrl.sv ====
//--------------------
// axi read controller
// one burst at a time over ar and r, walks the
// beat addresses and flags the last beat
//--------------------
`timescale 1ns/10ps

module axi_read_ctrl #(
    parameter int ID_WIDTH = 4
) (
    input  logic                S_AXI_ACLK,
    input  logic                S_AXI_ARESETN,
    input  logic [ID_WIDTH-1:0] S_AXI_ARID,
    input  perip_pkg::addr_t    S_AXI_ARADDR,
    input  perip_pkg::axi_len_t S_AXI_ARLEN,
    input  perip_pkg::burst_t   S_AXI_ARBURST,
    input  logic                S_AXI_ARVALID,
    output logic                S_AXI_ARREADY,
    output logic [ID_WIDTH-1:0] S_AXI_RID,
    output perip_pkg::resp_t    S_AXI_RRESP,
    output logic                S_AXI_RLAST,
    output logic                S_AXI_RVALID,
    input  logic                S_AXI_RREADY,
    output perip_pkg::addr_t    rd_addr
);

    perip_pkg::rd_state_t state;
    logic [ID_WIDTH-1:0]  ar_id;
    perip_pkg::burst_t    ar_burst;
    perip_pkg::axi_len_t  ar_len;
    perip_pkg::addr_t     beat_addr;
    perip_pkg::addr_t     next_addr;
    perip_pkg::axi_len_t  beat_cnt;
    logic                 ar_hs;
    logic                 r_hs;

    assign S_AXI_ARREADY = (state == perip_pkg::RD_IDLE);
    assign S_AXI_RVALID  = (state == perip_pkg::RD_DATA);
    assign S_AXI_RID     = ar_id;
    assign S_AXI_RRESP   = perip_pkg::RESP_OKAY;
    assign S_AXI_RLAST   = S_AXI_RVALID && (beat_cnt == ar_len);

    assign ar_hs = S_AXI_ARVALID && S_AXI_ARREADY;
    assign r_hs  = S_AXI_RVALID && S_AXI_RREADY;

    assign rd_addr = beat_addr;  // rdata follows combinationally

    axi_burst_addr i_axi_burst_addr (
        .cur_addr  (beat_addr),
        .burst     (ar_burst),
        .len       (ar_len),
        .next_addr (next_addr)
    );

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            state <= perip_pkg::RD_IDLE;
        end else begin
            case (state)
                perip_pkg::RD_IDLE: if (ar_hs) state <= perip_pkg::RD_DATA;
                perip_pkg::RD_DATA: if (r_hs && S_AXI_RLAST) state <= perip_pkg::RD_IDLE;
                default:            state <= perip_pkg::RD_IDLE;
            endcase
        end
    end

    // burst context; holds while rready is low
    always_ff @(posedge S_AXI_ACLK) begin
        if (ar_hs) begin
            ar_id     <= S_AXI_ARID;
            ar_burst  <= S_AXI_ARBURST;
            ar_len    <= S_AXI_ARLEN;
            beat_addr <= S_AXI_ARADDR;
            beat_cnt  <= '0;
        end else if (r_hs) begin
            beat_addr <= next_addr;
            beat_cnt  <= beat_cnt + 8'd1;
        end
    end

endmodule

// ==== perip_regs.sv ====
//--------------------
// virtual peripheral registers
// led and seven-segment registers with byte strobes,
// switch and key inputs, read decode over the map
//--------------------
`timescale 1ns/10ps

module perip_regs (
    input  logic                     S_AXI_ACLK,
    input  logic                     S_AXI_ARESETN,
    input  perip_pkg::perip_wr_req_t wr_req,
    input  logic                     wr_en,
    input  perip_pkg::addr_t         rd_addr,
    input  logic [63:0]              sw_in,
    input  logic [7:0]               key_in,
    output perip_pkg::data_t         rd_data,
    output logic [39:0]              seg_out,
    output logic [31:0]              led_out
);

    perip_pkg::data_t led_r;
    perip_pkg::data_t seg_lo_r;
    logic [7:0]       seg_hi_r;
    perip_pkg::addr_t wr_off;
    perip_pkg::addr_t rd_off;
    logic             wr_hit;
    logic             rd_hit;

    // merge the strobed bytes of a new word over an old one
    function automatic perip_pkg::data_t strobe_merge(
        input perip_pkg::data_t old_w,
        input perip_pkg::data_t new_w,
        input perip_pkg::strb_t strb
    );
        perip_pkg::data_t res;
        res = old_w;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) res[8*i +: 8] = new_w[8*i +: 8];
        end
        return res;
    endfunction

    // map lives below 0x20; byte lanes ignored
    assign wr_hit = (wr_req.addr[15:5] == '0);
    assign rd_hit = (rd_addr[15:5] == '0);
    assign wr_off = wr_req.addr & 16'h001c;
    assign rd_off = rd_addr & 16'h001c;

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            led_r    <= '0;
            seg_lo_r <= '0;
            seg_hi_r <= '0;
        end else if (wr_en && wr_hit) begin
            case (wr_off)
                perip_pkg::REG_LED:    led_r <= strobe_merge(led_r, wr_req.data, wr_req.strb);
                perip_pkg::REG_SEG_LO: seg_lo_r <= strobe_merge(seg_lo_r, wr_req.data, wr_req.strb);
                perip_pkg::REG_SEG_HI: if (wr_req.strb[0]) seg_hi_r <= wr_req.data[7:0];
                default: ;  // switch, key and gaps are read-only
            endcase
        end
    end

    always_comb begin
        rd_data = '0;
        if (rd_hit) begin
            case (rd_off)
                perip_pkg::REG_LED:    rd_data = led_r;
                perip_pkg::REG_SEG_LO: rd_data = seg_lo_r;
                perip_pkg::REG_SEG_HI: rd_data = {24'd0, seg_hi_r};
                perip_pkg::REG_SW_LO:  rd_data = sw_in[31:0];
                perip_pkg::REG_SW_HI:  rd_data = sw_in[63:32];
                perip_pkg::REG_KEY:    rd_data = {24'd0, key_in};
                default:               rd_data = '0;
            endcase
        end
    end

    assign led_out = led_r;
    assign seg_out = {seg_hi_r, seg_lo_r};  // digit 4 on top

endmodule

// ==== perip_bridge_axi.sv ====
//--------------------
// axi4 peripheral bridge
// axi4 slave in front of the virtual board registers,
// separate write and read controllers
//--------------------
`timescale 1ns/10ps

module perip_bridge_axi #(
    parameter int ID_WIDTH = 4
) (
    input  logic                S_AXI_ACLK,
    input  logic                S_AXI_ARESETN,
    // write address
    input  logic [ID_WIDTH-1:0] S_AXI_AWID,
    input  perip_pkg::addr_t    S_AXI_AWADDR,
    input  perip_pkg::axi_len_t S_AXI_AWLEN,
    input  perip_pkg::burst_t   S_AXI_AWBURST,
    input  logic                S_AXI_AWVALID,
    output logic                S_AXI_AWREADY,
    // write data
    input  perip_pkg::data_t    S_AXI_WDATA,
    input  perip_pkg::strb_t    S_AXI_WSTRB,
    input  logic                S_AXI_WLAST,
    input  logic                S_AXI_WVALID,
    output logic                S_AXI_WREADY,
    // write response
    output logic [ID_WIDTH-1:0] S_AXI_BID,
    output perip_pkg::resp_t    S_AXI_BRESP,
    output logic                S_AXI_BVALID,
    input  logic                S_AXI_BREADY,
    // read address
    input  logic [ID_WIDTH-1:0] S_AXI_ARID,
    input  perip_pkg::addr_t    S_AXI_ARADDR,
    input  perip_pkg::axi_len_t S_AXI_ARLEN,
    input  perip_pkg::burst_t   S_AXI_ARBURST,
    input  logic                S_AXI_ARVALID,
    output logic                S_AXI_ARREADY,
    // read data
    output logic [ID_WIDTH-1:0] S_AXI_RID,
    output perip_pkg::data_t    S_AXI_RDATA,
    output perip_pkg::resp_t    S_AXI_RRESP,
    output logic                S_AXI_RLAST,
    output logic                S_AXI_RVALID,
    input  logic                S_AXI_RREADY,
    // board pins
    input  logic [63:0]         sw_in,
    input  logic [7:0]          key_in,
    output logic [39:0]         seg_out,
    output logic [31:0]         led_out
);

    perip_pkg::perip_wr_req_t wr_req;
    logic                     wr_en;
    perip_pkg::addr_t         rd_addr;

    axi_write_ctrl #(.ID_WIDTH(ID_WIDTH)) i_axi_write_ctrl (
        .S_AXI_ACLK, .S_AXI_ARESETN,
        .S_AXI_AWID, .S_AXI_AWADDR, .S_AXI_AWLEN, .S_AXI_AWBURST,
        .S_AXI_AWVALID, .S_AXI_AWREADY,
        .S_AXI_WDATA, .S_AXI_WSTRB, .S_AXI_WLAST, .S_AXI_WVALID, .S_AXI_WREADY,
        .S_AXI_BID, .S_AXI_BRESP, .S_AXI_BVALID, .S_AXI_BREADY,
        .wr_req, .wr_en
    );

    axi_read_ctrl #(.ID_WIDTH(ID_WIDTH)) i_axi_read_ctrl (
        .S_AXI_ACLK, .S_AXI_ARESETN,
        .S_AXI_ARID, .S_AXI_ARADDR, .S_AXI_ARLEN, .S_AXI_ARBURST,
        .S_AXI_ARVALID, .S_AXI_ARREADY,
        .S_AXI_RID, .S_AXI_RRESP, .S_AXI_RLAST, .S_AXI_RVALID, .S_AXI_RREADY,
        .rd_addr
    );

    // register data goes straight out on rdata
    perip_regs i_perip_regs (
        .S_AXI_ACLK, .S_AXI_ARESETN,
        .wr_req, .wr_en, .rd_addr,
        .sw_in, .key_in,
        .rd_data (S_AXI_RDATA),
        .seg_out, .led_out
    );

endmodule

// ==== tb_clock_gen.sv ====
//--------------------
// testbench clock and reset
// 8 ns clock, reset low for 16 cycles
//--------------------
`timescale 1ns/10ps

module tb_clock_gen (
    output logic S_AXI_ACLK,
    output logic S_AXI_ARESETN
);

    initial begin
        S_AXI_ACLK = 1'b0;
        forever #4 S_AXI_ACLK = ~S_AXI_ACLK;
    end

    initial begin
        S_AXI_ARESETN = 1'b0;
        repeat (16) @(posedge S_AXI_ACLK);
        #1 S_AXI_ARESETN = 1'b1;   // released off the edge
    end

endmodule

// ==== tb_perip_bridge_axi.sv ====
//--------------------
// testbench for the axi4 peripheral bridge
// table of write and read bursts applied in a loop,
// random ready stalls, data, id, response and pin checks
//--------------------
`timescale 1ns/10ps

module tb_perip_bridge_axi;

    localparam int ID_WIDTH = 4;
    localparam int TIMEOUT  = 200;   // cycles per wait

    localparam perip_pkg::burst_t FIXED = perip_pkg::BURST_FIXED;
    localparam perip_pkg::burst_t INCR  = perip_pkg::BURST_INCR;
    localparam perip_pkg::burst_t WRAP  = perip_pkg::BURST_WRAP;

    // one burst of the table with beat 0 leftmost
    typedef struct packed {
        logic                   is_write;
        logic [ID_WIDTH-1:0]    id;
        perip_pkg::addr_t       addr;
        perip_pkg::axi_len_t    len;
        perip_pkg::burst_t      burst;
        perip_pkg::data_t [0:3] data;
        perip_pkg::strb_t [0:3] strb;
        perip_pkg::data_t [0:3] exp;
        logic [31:0]            exp_led;
        logic [39:0]            exp_seg;
    } row_t;

    logic                S_AXI_ACLK;
    logic                S_AXI_ARESETN;
    logic [ID_WIDTH-1:0] S_AXI_AWID;
    perip_pkg::addr_t    S_AXI_AWADDR;
    perip_pkg::axi_len_t S_AXI_AWLEN;
    perip_pkg::burst_t   S_AXI_AWBURST;
    logic                S_AXI_AWVALID;
    logic                S_AXI_AWREADY;
    perip_pkg::data_t    S_AXI_WDATA;
    perip_pkg::strb_t    S_AXI_WSTRB;
    logic                S_AXI_WLAST;
    logic                S_AXI_WVALID;
    logic                S_AXI_WREADY;
    logic [ID_WIDTH-1:0] S_AXI_BID;
    perip_pkg::resp_t    S_AXI_BRESP;
    logic                S_AXI_BVALID;
    logic                S_AXI_BREADY;
    logic [ID_WIDTH-1:0] S_AXI_ARID;
    perip_pkg::addr_t    S_AXI_ARADDR;
    perip_pkg::axi_len_t S_AXI_ARLEN;
    perip_pkg::burst_t   S_AXI_ARBURST;
    logic                S_AXI_ARVALID;
    logic                S_AXI_ARREADY;
    logic [ID_WIDTH-1:0] S_AXI_RID;
    perip_pkg::data_t    S_AXI_RDATA;
    perip_pkg::resp_t    S_AXI_RRESP;
    logic                S_AXI_RLAST;
    logic                S_AXI_RVALID;
    logic                S_AXI_RREADY;
    logic [63:0]         sw_in;
    logic [7:0]          key_in;
    logic [39:0]         seg_out;
    logic [31:0]         led_out;

    row_t        rows[$];
    logic [31:0] rnd;

    tb_clock_gen i_tb_clock_gen (.S_AXI_ACLK, .S_AXI_ARESETN);

    perip_bridge_axi #(.ID_WIDTH(ID_WIDTH)) i_perip_bridge_axi (.*);

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic check_data(input string name, input perip_pkg::data_t got,
                              input perip_pkg::data_t exp);
        if (got !== exp)
            stop_run($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_resp(input string name, input perip_pkg::resp_t got,
                              input perip_pkg::resp_t exp);
        if (got !== exp)
            stop_run($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_id(input string name, input logic [ID_WIDTH-1:0] got,
                            input logic [ID_WIDTH-1:0] exp);
        if (got !== exp)
            stop_run($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_last(input string name, input logic got, input logic exp);
        if (got !== exp)
            stop_run($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_pins(input logic [31:0] exp_led, input logic [39:0] exp_seg);
        if (led_out !== exp_led)
            stop_run($sformatf("MISMATCH led_out got %h expected %h", led_out, exp_led));
        if (seg_out !== exp_seg)
            stop_run($sformatf("MISMATCH seg_out got %h expected %h", seg_out, exp_seg));
    endtask

    task automatic next_cycle();
        @(posedge S_AXI_ACLK);
        #1;
    endtask

    task automatic add_write(input logic [ID_WIDTH-1:0] id, input perip_pkg::addr_t addr,
                             input perip_pkg::axi_len_t len, input perip_pkg::burst_t burst,
                             input perip_pkg::data_t [0:3] data,
                             input perip_pkg::strb_t [0:3] strb,
                             input logic [31:0] exp_led, input logic [39:0] exp_seg);
        rows.push_back({1'b1, id, addr, len, burst, data, strb, 128'd0, exp_led, exp_seg});
    endtask

    task automatic add_read(input logic [ID_WIDTH-1:0] id, input perip_pkg::addr_t addr,
                            input perip_pkg::axi_len_t len, input perip_pkg::burst_t burst,
                            input perip_pkg::data_t [0:3] exp,
                            input logic [31:0] exp_led, input logic [39:0] exp_seg);
        rows.push_back({1'b0, id, addr, len, burst, 128'd0, 16'd0, exp, exp_led, exp_seg});
    endtask

    task automatic build_table();
        // single beats, partial strobes, unaligned low bits
        add_write(4'd3, 16'h0000, 8'd0, INCR, {32'hA1B2C3D4, 96'd0}, {4'b0101, 12'd0},
                  32'h00B200D4, 40'h00_0000_0000);
        add_write(4'd5, 16'h0004, 8'd0, INCR, {32'h11223344, 96'd0}, {4'b1100, 12'd0},
                  32'h00B200D4, 40'h00_1122_0000);
        add_write(4'd6, 16'h0008, 8'd0, INCR, {32'hFFFFFF5A, 96'd0}, {4'b0001, 12'd0},
                  32'h00B200D4, 40'h5A_1122_0000);
        add_write(4'd10, 16'h0002, 8'd0, INCR, {32'h77665544, 96'd0}, {4'b1010, 12'd0},
                  32'h77B255D4, 40'h5A_1122_0000);
        // switch, switch, key, gap
        add_read(4'd9, 16'h0010, 8'd3, INCR,
                 {sw_in[31:0], sw_in[63:32], {24'd0, key_in}, 32'd0},
                 32'h77B255D4, 40'h5A_1122_0000);
        add_write(4'd1, 16'h0000, 8'd2, INCR,
                  {32'hCAFE0001, 32'h12345678, 32'hABCDEF99, 32'd0}, {12'hfff, 4'h0},
                  32'hCAFE0001, 40'h99_1234_5678);
        add_read(4'd2, 16'h0004, 8'd2, FIXED, {{3{32'h12345678}}, 32'd0},
                 32'hCAFE0001, 40'h99_1234_5678);
        add_read(4'd4, 16'h0000, 8'd2, INCR,
                 {32'hCAFE0001, 32'h12345678, 32'h00000099, 32'd0},
                 32'hCAFE0001, 40'h99_1234_5678);
        // wrap from 0x08 lands at 0x08, 0x0c, 0x00, 0x04
        add_write(4'd12, 16'h0008, 8'd3, WRAP,
                  {32'h000000C3, 32'hDEADBEEF, 32'h5555AAAA, 32'h87654321}, 16'hffff,
                  32'h5555AAAA, 40'hC3_8765_4321);
        add_read(4'd13, 16'h0000, 8'd3, INCR,
                 {32'h5555AAAA, 32'h87654321, 32'h000000C3, 32'd0},
                 32'h5555AAAA, 40'hC3_8765_4321);
        add_read(4'd11, 16'h000C, 8'd3, WRAP,
                 {32'd0, 32'h5555AAAA, 32'h87654321, 32'h000000C3},
                 32'h5555AAAA, 40'hC3_8765_4321);
        // read-only and unmapped targets
        add_write(4'd7, 16'h0010, 8'd0, INCR, {32'hFFFFFFFF, 96'd0}, {4'hf, 12'd0},
                  32'h5555AAAA, 40'hC3_8765_4321);
        add_write(4'd8, 16'h0040, 8'd0, INCR, {32'h0BADF00D, 96'd0}, {4'hf, 12'd0},
                  32'h5555AAAA, 40'hC3_8765_4321);
        add_read(4'd14, 16'h0040, 8'd0, INCR, 128'd0, 32'h5555AAAA, 40'hC3_8765_4321);
        add_read(4'd15, 16'h0000, 8'd2, INCR,
                 {32'h5555AAAA, 32'h87654321, 32'h000000C3, 32'd0},
                 32'h5555AAAA, 40'hC3_8765_4321);
    endtask

    task automatic run_write(input row_t row);
        int n;
        int b;
        S_AXI_AWID    = row.id;
        S_AXI_AWADDR  = row.addr;
        S_AXI_AWLEN   = row.len;
        S_AXI_AWBURST = row.burst;
        S_AXI_AWVALID = 1'b1;
        n = 0;
        @(negedge S_AXI_ACLK);
        while (!S_AXI_AWREADY) begin
            n++;
            if (n > TIMEOUT) stop_run("timeout waiting for AWREADY");
            @(negedge S_AXI_ACLK);
        end
        next_cycle();
        S_AXI_AWVALID = 1'b0;
        S_AXI_AWID    = '0;   // aw fields no longer valid
        S_AXI_AWADDR  = '0;
        S_AXI_AWLEN   = '0;
        S_AXI_AWBURST = '0;
        for (b = 0; b <= row.len; b++) begin
            repeat ($urandom_range(2, 0)) next_cycle();   // idle gap on w
            S_AXI_WDATA  = row.data[b];
            S_AXI_WSTRB  = row.strb[b];
            S_AXI_WLAST  = (b == row.len);
            S_AXI_WVALID = 1'b1;
            n = 0;
            @(negedge S_AXI_ACLK);
            while (!S_AXI_WREADY) begin
                n++;
                if (n > TIMEOUT) stop_run("timeout waiting for WREADY");
                @(negedge S_AXI_ACLK);
            end
            next_cycle();
            S_AXI_WVALID = 1'b0;
            S_AXI_WLAST  = 1'b0;
        end
        repeat ($urandom_range(3, 0)) next_cycle();
        S_AXI_BREADY = 1'b1;
        n = 0;
        @(negedge S_AXI_ACLK);
        while (!S_AXI_BVALID) begin
            n++;
            if (n > TIMEOUT) stop_run("timeout waiting for BVALID");
            @(negedge S_AXI_ACLK);
        end
        check_id("BID", S_AXI_BID, row.id);
        check_resp("BRESP", S_AXI_BRESP, perip_pkg::RESP_OKAY);
        next_cycle();
        S_AXI_BREADY = 1'b0;
    endtask

    task automatic run_read(input row_t row);
        int n;
        int b;
        S_AXI_ARID    = row.id;
        S_AXI_ARADDR  = row.addr;
        S_AXI_ARLEN   = row.len;
        S_AXI_ARBURST = row.burst;
        S_AXI_ARVALID = 1'b1;
        n = 0;
        @(negedge S_AXI_ACLK);
        while (!S_AXI_ARREADY) begin
            n++;
            if (n > TIMEOUT) stop_run("timeout waiting for ARREADY");
            @(negedge S_AXI_ACLK);
        end
        next_cycle();
        S_AXI_ARVALID = 1'b0;
        S_AXI_ARID    = '0;   // ar fields no longer valid
        S_AXI_ARADDR  = '0;
        S_AXI_ARLEN   = '0;
        S_AXI_ARBURST = '0;
        for (b = 0; b <= row.len; b++) begin
            S_AXI_RREADY = 1'b0;
            repeat ($urandom_range(3, 0)) next_cycle();   // stall the slave
            S_AXI_RREADY = 1'b1;
            n = 0;
            @(negedge S_AXI_ACLK);
            while (!S_AXI_RVALID) begin
                n++;
                if (n > TIMEOUT) stop_run("timeout waiting for RVALID");
                @(negedge S_AXI_ACLK);
            end
            check_data("RDATA", S_AXI_RDATA, row.exp[b]);
            check_id("RID", S_AXI_RID, row.id);
            check_resp("RRESP", S_AXI_RRESP, perip_pkg::RESP_OKAY);
            check_last("RLAST", S_AXI_RLAST, b == row.len);
            next_cycle();
        end
        S_AXI_RREADY = 1'b0;
    endtask

    initial begin
        int n;
        void'($urandom(32'hcf4e0792));
        S_AXI_AWID    = '0;
        S_AXI_AWADDR  = '0;
        S_AXI_AWLEN   = '0;
        S_AXI_AWBURST = '0;
        S_AXI_AWVALID = 1'b0;
        S_AXI_WDATA   = '0;
        S_AXI_WSTRB   = '0;
        S_AXI_WLAST   = 1'b0;
        S_AXI_WVALID  = 1'b0;
        S_AXI_BREADY  = 1'b0;
        S_AXI_ARID    = '0;
        S_AXI_ARADDR  = '0;
        S_AXI_ARLEN   = '0;
        S_AXI_ARBURST = '0;
        S_AXI_ARVALID = 1'b0;
        S_AXI_RREADY  = 1'b0;
        sw_in         = {$urandom(), $urandom()};
        rnd           = $urandom();
        key_in        = rnd[7:0];
        build_table();

        n = 0;
        while (S_AXI_ARESETN !== 1'b1) begin
            n++;
            if (n > TIMEOUT) stop_run("reset was never released");
            next_cycle();
        end
        next_cycle();
        @(negedge S_AXI_ACLK);
        // idle state right after reset
        check_last("AWREADY", S_AXI_AWREADY, 1'b1);
        check_last("ARREADY", S_AXI_ARREADY, 1'b1);
        check_last("WREADY", S_AXI_WREADY, 1'b0);
        check_last("BVALID", S_AXI_BVALID, 1'b0);
        check_last("RVALID", S_AXI_RVALID, 1'b0);
        check_pins(32'd0, 40'd0);
        next_cycle();

        for (int i = 0; i < rows.size(); i++) begin
            if (rows[i].is_write) begin
                run_write(rows[i]);
            end else begin
                run_read(rows[i]);
            end
            check_pins(rows[i].exp_led, rows[i].exp_seg);
        end

        $display("Done: no errors");
        $finish;
    end

endmodule

// ==== vlog.f ====
perip_pkg.sv
axi_burst_addr.sv
axi_write_ctrl.sv
axi_read_ctrl.sv
perip_regs.sv
perip_bridge_axi.sv
tb_clock_gen.sv
tb_perip_bridge_axi.sv
